// ==== source/dma_axi_pkg.sv ====
`default_nettype none

package dma_axi_pkg;

    //////////////////////////////////////////////////////////////////////
    // AXI4 field widths
    //////////////////////////////////////////////////////////////////////

    // the AXI4 spec fixes axlen at 8 bits even when bursts are shorter
    localparam int AXI_LEN_WIDTH = 8;

    // axsize carries the log2 of the bytes moved per beat
    localparam int AXI_SIZE_WIDTH = 3;

    localparam int AXI_BURST_WIDTH = 2;

    //////////////////////////////////////////////////////////////////////
    // AXI4 types
    //////////////////////////////////////////////////////////////////////

    // burst type encodings come from the AXI4 spec
    // this core only ever issues incrementing bursts
    typedef enum logic [AXI_BURST_WIDTH-1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } axi_burst_e;

    typedef logic [AXI_LEN_WIDTH-1:0] axi_len_t;

endpackage

`default_nettype wire

// ==== source/dma_cfg_pkg.sv ====
`default_nettype none

package dma_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // DDR geometry
    //////////////////////////////////////////////////////////////////////

    // byte address into global memory
    localparam int DDR_ADDR_WIDTH = 32;
    localparam int DDR_DATA_BYTES = 4;

    // internal burst length field, a burst holds 2**DDR_BURST_WIDTH words
    localparam int DDR_BURST_WIDTH = 2;
    localparam int BURST_WORDS = 2 ** DDR_BURST_WIDTH;
    localparam int BURST_BYTES = BURST_WORDS * DDR_DATA_BYTES;

    // every beat moves a whole DDR word
    localparam int DDR_SIZE_CODE = $clog2(DDR_DATA_BYTES);

    //////////////////////////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////////////////////////

    typedef logic [DDR_ADDR_WIDTH-1:0]   ddr_addr_t;
    typedef logic [8*DDR_DATA_BYTES-1:0] ddr_data_t;
    typedef logic [DDR_DATA_BYTES-1:0]   ddr_strb_t;
    typedef logic [DDR_BURST_WIDTH-1:0]  burst_len_t;

    // a descriptor names its length in whole bursts
    typedef logic [7:0] burst_count_t;

    // the reader and writer each run a two state control loop
    typedef enum logic {RD_IDLE, RD_ACTIVE} rd_state_e;
    typedef enum logic {WR_IDLE, WR_ACTIVE} wr_state_e;

endpackage

`default_nettype wire

// ==== source/dma_feature_reader.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_feature_reader (
    input  wire                       clk_ddr,
    input  wire                       i_rst,

    // read descriptor
    input  wire                       i_rd_start,
    input  dma_cfg_pkg::ddr_addr_t    i_rd_addr,
    input  dma_cfg_pkg::burst_count_t i_rd_bursts,

    // read address channel towards the prioritizer
    output logic                      o_ddr_arvalid,
    output dma_cfg_pkg::ddr_addr_t    o_ddr_araddr,
    output dma_cfg_pkg::burst_len_t   o_ddr_arlen,
    input  wire                       i_ddr_arready,

    // read data channel from DDR
    input  wire                       i_ddr_rvalid,
    input  dma_cfg_pkg::ddr_data_t    i_ddr_rdata,
    output logic                      o_ddr_rready,

    // outgoing read stream
    output logic                      o_rd_valid,
    output dma_cfg_pkg::ddr_data_t    o_rd_data,
    input  wire                       i_rd_ready,

    output logic                      o_rd_busy,
    output logic                      o_rd_done
);

    import dma_cfg_pkg::*;

    rd_state_e    state;
    burst_count_t req_left;
    // beats still to come back, bursts times BURST_WORDS
    logic [$bits(burst_count_t)+DDR_BURST_WIDTH-1:0] beats_left;
    logic         ar_fire;
    logic         r_fire;

    // the R channel is not buffered here, so the stream consumer
    // throttles DDR directly through rready
    assign o_rd_valid   = i_ddr_rvalid;
    assign o_rd_data    = i_ddr_rdata;
    assign o_ddr_rready = i_rd_ready;

    // every burst is a full one
    assign o_ddr_arlen = burst_len_t'(BURST_WORDS - 1);
    assign o_rd_busy   = (state == RD_ACTIVE);

    assign ar_fire = o_ddr_arvalid & i_ddr_arready;
    // beats only count against a running descriptor
    assign r_fire  = i_ddr_rvalid & i_rd_ready & o_rd_busy;

    //////////////////////////////////////////////////////////////////////
    // request and beat counting
    //////////////////////////////////////////////////////////////////////

    // requests and returning beats are counted apart, so several
    // bursts can be in flight while earlier data is still streaming
    always_ff @(posedge clk_ddr) begin
        if (i_rst) begin
            state         <= RD_IDLE;
            o_ddr_arvalid <= 1'b0;
            o_rd_done     <= 1'b0;
            req_left      <= '0;
            beats_left    <= '0;
        end else begin
            o_rd_done <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (i_rd_start) begin
                        state         <= RD_ACTIVE;
                        o_ddr_arvalid <= 1'b1;
                        req_left      <= i_rd_bursts;
                        beats_left    <= {i_rd_bursts, {DDR_BURST_WIDTH{1'b0}}};
                    end
                end
                RD_ACTIVE: begin
                    // arvalid holds until the final request is taken
                    if (ar_fire) begin
                        req_left <= req_left - 1'b1;
                        if (req_left == burst_count_t'(1)) begin
                            o_ddr_arvalid <= 1'b0;
                        end
                    end
                    if (r_fire) begin
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == 1) begin
                            state     <= RD_IDLE;
                            o_rd_done <= 1'b1;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // the address moves one burst on each accepted request
    always_ff @(posedge clk_ddr) begin
        if (!o_rd_busy && i_rd_start) begin
            o_ddr_araddr <= i_rd_addr;
        end else if (ar_fire) begin
            o_ddr_araddr <= o_ddr_araddr + ddr_addr_t'(BURST_BYTES);
        end
    end

endmodule

`default_nettype wire

// ==== source/dma_feature_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_feature_writer (
    input  wire                       clk_ddr,
    input  wire                       i_rst,

    // write descriptor
    input  wire                       i_wr_start,
    input  dma_cfg_pkg::ddr_addr_t    i_wr_addr,
    input  dma_cfg_pkg::burst_count_t i_wr_bursts,

    // incoming write stream
    input  wire                       i_wr_valid,
    input  dma_cfg_pkg::ddr_data_t    i_wr_data,
    output logic                      o_wr_ready,

    // write address channel
    output logic                      o_ddr_awvalid,
    output dma_cfg_pkg::ddr_addr_t    o_ddr_awaddr,
    output dma_cfg_pkg::burst_len_t   o_ddr_awlen,
    input  wire                       i_ddr_awready,

    // write data channel
    output logic                      o_ddr_wvalid,
    output dma_cfg_pkg::ddr_data_t    o_ddr_wdata,
    output dma_cfg_pkg::ddr_strb_t    o_ddr_wstrb,
    output logic                      o_ddr_wlast,
    input  wire                       i_ddr_wready,

    // write response channel
    input  wire                       i_ddr_bvalid,
    output logic                      o_ddr_bready,

    output logic                      o_wr_busy,
    output logic                      o_wr_done
);

    import dma_cfg_pkg::*;

    wr_state_e    state;
    burst_count_t aw_left;
    burst_count_t b_left;
    logic [$bits(burst_count_t)+DDR_BURST_WIDTH-1:0] w_left;
    // position of the current beat inside its burst
    burst_len_t   beat_idx;
    logic         w_owed;
    logic         aw_fire;
    logic         w_fire;
    logic         b_fire;

    assign o_wr_busy = (state == WR_ACTIVE);
    assign w_owed    = o_wr_busy && (w_left != '0);

    // the stream maps onto the W channel beat for beat
    assign o_ddr_wvalid = w_owed & i_wr_valid;
    assign o_wr_ready   = w_owed & i_ddr_wready;
    assign o_ddr_wdata  = i_wr_data;
    assign o_ddr_wstrb  = '1;
    assign o_ddr_wlast  = (beat_idx == burst_len_t'(BURST_WORDS - 1));

    assign o_ddr_awlen  = burst_len_t'(BURST_WORDS - 1);
    // responses are always welcome while a descriptor runs
    assign o_ddr_bready = o_wr_busy;

    assign aw_fire = o_ddr_awvalid & i_ddr_awready;
    assign w_fire  = o_ddr_wvalid & i_ddr_wready;
    assign b_fire  = i_ddr_bvalid & o_ddr_bready;

    //////////////////////////////////////////////////////////////////////
    // AW, W and B counters
    //////////////////////////////////////////////////////////////////////

    // the three channels advance on their own, so W may run ahead of
    // or behind AW, and only the last B closes the descriptor
    always_ff @(posedge clk_ddr) begin
        if (i_rst) begin
            state         <= WR_IDLE;
            o_ddr_awvalid <= 1'b0;
            o_wr_done     <= 1'b0;
            aw_left       <= '0;
            w_left        <= '0;
            b_left        <= '0;
            beat_idx      <= '0;
        end else begin
            o_wr_done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (i_wr_start) begin
                        state         <= WR_ACTIVE;
                        o_ddr_awvalid <= 1'b1;
                        aw_left       <= i_wr_bursts;
                        b_left        <= i_wr_bursts;
                        w_left        <= {i_wr_bursts, {DDR_BURST_WIDTH{1'b0}}};
                        beat_idx      <= '0;
                    end
                end
                WR_ACTIVE: begin
                    if (aw_fire) begin
                        aw_left <= aw_left - 1'b1;
                        if (aw_left == burst_count_t'(1)) begin
                            o_ddr_awvalid <= 1'b0;
                        end
                    end
                    // beat_idx wraps on its own after the wlast beat
                    if (w_fire) begin
                        w_left   <= w_left - 1'b1;
                        beat_idx <= beat_idx + 1'b1;
                    end
                    if (b_fire) begin
                        b_left <= b_left - 1'b1;
                        if (b_left == burst_count_t'(1)) begin
                            state     <= WR_IDLE;
                            o_wr_done <= 1'b1;
                        end
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // the write address steps one burst per accepted AW
    always_ff @(posedge clk_ddr) begin
        if (!o_wr_busy && i_wr_start) begin
            o_ddr_awaddr <= i_wr_addr;
        end else if (aw_fire) begin
            o_ddr_awaddr <= o_ddr_awaddr + ddr_addr_t'(BURST_BYTES);
        end
    end

endmodule

`default_nettype wire

// ==== source/dma_ddr_prioritizer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_ddr_prioritizer (
    input  wire                                        clk_ddr,
    input  wire                                        i_rst,

    // requests from the reader and the writer
    input  wire                                        i_rd_arvalid,
    input  dma_cfg_pkg::burst_len_t                    i_rd_arlen,
    output logic                                       o_rd_arready,
    input  wire                                        i_wr_awvalid,
    input  dma_cfg_pkg::burst_len_t                    i_wr_awlen,
    output logic                                       o_wr_awready,
    input  wire                                        i_wr_wvalid,
    output logic                                       o_wr_wready,

    // DDR side of the AR, AW and W handshakes
    output logic                                       o_ddr_arvalid,
    output dma_axi_pkg::axi_len_t                      o_ddr_arlen,
    output logic [dma_axi_pkg::AXI_SIZE_WIDTH-1:0]     o_ddr_arsize,
    output dma_axi_pkg::axi_burst_e                    o_ddr_arburst,
    input  wire                                        i_ddr_arready,
    output logic                                       o_ddr_awvalid,
    output dma_axi_pkg::axi_len_t                      o_ddr_awlen,
    output logic [dma_axi_pkg::AXI_SIZE_WIDTH-1:0]     o_ddr_awsize,
    output dma_axi_pkg::axi_burst_e                    o_ddr_awburst,
    input  wire                                        i_ddr_awready,
    output logic                                       o_ddr_wvalid,
    input  wire                                        i_ddr_wready
);

    import dma_axi_pkg::*;
    import dma_cfg_pkg::*;

    // set when last cycle showed arvalid without arready
    logic rd_hold;
    logic wr_wins;

    //////////////////////////////////////////////////////////////////////
    // write over read priority
    //////////////////////////////////////////////////////////////////////

    // a pending read must keep arvalid up until DDR takes it, so all
    // write traffic waits for that one cycle at least
    assign o_ddr_awvalid = i_wr_awvalid & ~rd_hold;
    assign o_ddr_wvalid  = i_wr_wvalid & ~rd_hold;
    assign o_wr_awready  = i_ddr_awready & ~rd_hold;
    assign o_wr_wready   = i_ddr_wready & ~rd_hold;

    // with no read held, any write activity keeps a new read back
    // R and B are left alone since returning data never conflicts
    assign wr_wins       = o_ddr_awvalid | o_ddr_wvalid;
    assign o_ddr_arvalid = i_rd_arvalid & ~wr_wins;
    assign o_rd_arready  = i_ddr_arready & ~wr_wins;

    always_ff @(posedge clk_ddr) begin
        if (i_rst) begin
            rd_hold <= 1'b0;
        end else begin
            rd_hold <= o_ddr_arvalid & ~i_ddr_arready;
        end
    end

    // internal burst lengths widen to the 8 bit AXI field
    assign o_ddr_arlen = axi_len_t'(i_rd_arlen);
    assign o_ddr_awlen = axi_len_t'(i_wr_awlen);

    // full width incrementing bursts on both address channels
    assign o_ddr_arsize  = AXI_SIZE_WIDTH'(DDR_SIZE_CODE);
    assign o_ddr_awsize  = AXI_SIZE_WIDTH'(DDR_SIZE_CODE);
    assign o_ddr_arburst = INCR;
    assign o_ddr_awburst = INCR;

endmodule

`default_nettype wire

// ==== source/dma_ddr_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_ddr_port (
    input  wire                                    clk_ddr,
    input  wire                                    i_rst,

    // descriptors
    input  wire                                    i_rd_start,
    input  dma_cfg_pkg::ddr_addr_t                 i_rd_addr,
    input  dma_cfg_pkg::burst_count_t              i_rd_bursts,
    input  wire                                    i_wr_start,
    input  dma_cfg_pkg::ddr_addr_t                 i_wr_addr,
    input  dma_cfg_pkg::burst_count_t              i_wr_bursts,

    // read and write streams
    output logic                                   o_rd_valid,
    output dma_cfg_pkg::ddr_data_t                 o_rd_data,
    input  wire                                    i_rd_ready,
    input  wire                                    i_wr_valid,
    input  dma_cfg_pkg::ddr_data_t                 i_wr_data,
    output logic                                   o_wr_ready,

    // status
    output logic                                   o_rd_busy,
    output logic                                   o_rd_done,
    output logic                                   o_wr_busy,
    output logic                                   o_wr_done,

    // AXI4 master to DDR
    output logic                                   o_ddr_arvalid,
    output dma_cfg_pkg::ddr_addr_t                 o_ddr_araddr,
    output dma_axi_pkg::axi_len_t                  o_ddr_arlen,
    output logic [dma_axi_pkg::AXI_SIZE_WIDTH-1:0] o_ddr_arsize,
    output dma_axi_pkg::axi_burst_e                o_ddr_arburst,
    input  wire                                    i_ddr_arready,
    input  wire                                    i_ddr_rvalid,
    input  dma_cfg_pkg::ddr_data_t                 i_ddr_rdata,
    output logic                                   o_ddr_rready,
    output logic                                   o_ddr_awvalid,
    output dma_cfg_pkg::ddr_addr_t                 o_ddr_awaddr,
    output dma_axi_pkg::axi_len_t                  o_ddr_awlen,
    output logic [dma_axi_pkg::AXI_SIZE_WIDTH-1:0] o_ddr_awsize,
    output dma_axi_pkg::axi_burst_e                o_ddr_awburst,
    input  wire                                    i_ddr_awready,
    output logic                                   o_ddr_wvalid,
    output dma_cfg_pkg::ddr_data_t                 o_ddr_wdata,
    output dma_cfg_pkg::ddr_strb_t                 o_ddr_wstrb,
    output logic                                   o_ddr_wlast,
    input  wire                                    i_ddr_wready,
    input  wire                                    i_ddr_bvalid,
    output logic                                   o_ddr_bready
);

    import dma_cfg_pkg::*;

    // reader and writer handshakes before the priority forcing
    logic       rd_arvalid;
    logic       rd_arready;
    burst_len_t rd_arlen;
    logic       wr_awvalid;
    logic       wr_awready;
    burst_len_t wr_awlen;
    logic       wr_wvalid;
    logic       wr_wready;

    dma_feature_reader u_reader (
        .clk_ddr       (clk_ddr),
        .i_rst         (i_rst),
        .i_rd_start    (i_rd_start),
        .i_rd_addr     (i_rd_addr),
        .i_rd_bursts   (i_rd_bursts),
        .o_ddr_arvalid (rd_arvalid),
        .o_ddr_araddr  (o_ddr_araddr),
        .o_ddr_arlen   (rd_arlen),
        .i_ddr_arready (rd_arready),
        .i_ddr_rvalid  (i_ddr_rvalid),
        .i_ddr_rdata   (i_ddr_rdata),
        .o_ddr_rready  (o_ddr_rready),
        .o_rd_valid    (o_rd_valid),
        .o_rd_data     (o_rd_data),
        .i_rd_ready    (i_rd_ready),
        .o_rd_busy     (o_rd_busy),
        .o_rd_done     (o_rd_done)
    );

    // address, data, strobe and last leave the writer directly, only the
    // valid and ready pairs pass through the prioritizer
    dma_feature_writer u_writer (
        .clk_ddr       (clk_ddr),
        .i_rst         (i_rst),
        .i_wr_start    (i_wr_start),
        .i_wr_addr     (i_wr_addr),
        .i_wr_bursts   (i_wr_bursts),
        .i_wr_valid    (i_wr_valid),
        .i_wr_data     (i_wr_data),
        .o_wr_ready    (o_wr_ready),
        .o_ddr_awvalid (wr_awvalid),
        .o_ddr_awaddr  (o_ddr_awaddr),
        .o_ddr_awlen   (wr_awlen),
        .i_ddr_awready (wr_awready),
        .o_ddr_wvalid  (wr_wvalid),
        .o_ddr_wdata   (o_ddr_wdata),
        .o_ddr_wstrb   (o_ddr_wstrb),
        .o_ddr_wlast   (o_ddr_wlast),
        .i_ddr_wready  (wr_wready),
        .i_ddr_bvalid  (i_ddr_bvalid),
        .o_ddr_bready  (o_ddr_bready),
        .o_wr_busy     (o_wr_busy),
        .o_wr_done     (o_wr_done)
    );

    dma_ddr_prioritizer u_prioritizer (
        .clk_ddr       (clk_ddr),
        .i_rst         (i_rst),
        .i_rd_arvalid  (rd_arvalid),
        .i_rd_arlen    (rd_arlen),
        .o_rd_arready  (rd_arready),
        .i_wr_awvalid  (wr_awvalid),
        .i_wr_awlen    (wr_awlen),
        .o_wr_awready  (wr_awready),
        .i_wr_wvalid   (wr_wvalid),
        .o_wr_wready   (wr_wready),
        .o_ddr_arvalid (o_ddr_arvalid),
        .o_ddr_arlen   (o_ddr_arlen),
        .o_ddr_arsize  (o_ddr_arsize),
        .o_ddr_arburst (o_ddr_arburst),
        .i_ddr_arready (i_ddr_arready),
        .o_ddr_awvalid (o_ddr_awvalid),
        .o_ddr_awlen   (o_ddr_awlen),
        .o_ddr_awsize  (o_ddr_awsize),
        .o_ddr_awburst (o_ddr_awburst),
        .i_ddr_awready (i_ddr_awready),
        .o_ddr_wvalid  (o_ddr_wvalid),
        .i_ddr_wready  (i_ddr_wready)
    );

endmodule

`default_nettype wire

// ==== verif/dma_ddr_port_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_ddr_port_asserts (
    input wire                                      clk_ddr,
    input wire                                      i_rst,
    input wire                                      o_ddr_arvalid,
    input wire                                      i_ddr_arready,
    input wire [dma_cfg_pkg::DDR_ADDR_WIDTH-1:0]    o_ddr_araddr,
    input wire [dma_axi_pkg::AXI_LEN_WIDTH-1:0]     o_ddr_arlen,
    input wire [dma_axi_pkg::AXI_SIZE_WIDTH-1:0]    o_ddr_arsize,
    input wire [dma_axi_pkg::AXI_BURST_WIDTH-1:0]   o_ddr_arburst,
    input wire                                      o_ddr_awvalid,
    input wire [dma_axi_pkg::AXI_LEN_WIDTH-1:0]     o_ddr_awlen,
    input wire [dma_axi_pkg::AXI_SIZE_WIDTH-1:0]    o_ddr_awsize,
    input wire [dma_axi_pkg::AXI_BURST_WIDTH-1:0]   o_ddr_awburst,
    input wire                                      o_ddr_wvalid
);

    import dma_axi_pkg::*;

    // write traffic always wins, so a read request never shares a cycle with it
    a_rd_excludes_wr: assert property (@(posedge clk_ddr) disable iff (i_rst)
        !(o_ddr_arvalid && (o_ddr_awvalid || o_ddr_wvalid)))
        else $error("arvalid high together with awvalid or wvalid");

    // once offered, a read request waits with its address until DDR takes it
    a_ar_held: assert property (@(posedge clk_ddr) disable iff (i_rst)
        o_ddr_arvalid && !i_ddr_arready |=> o_ddr_arvalid && $stable(o_ddr_araddr))
        else $error("unacknowledged read request dropped or changed address");

    // every burst is four words long
    a_len: assert property (@(posedge clk_ddr) disable iff (i_rst)
        o_ddr_arlen == 8'd3 && o_ddr_awlen == 8'd3)
        else $error("burst length is not four beats");

    a_burst_type: assert property (@(posedge clk_ddr) disable iff (i_rst)
        o_ddr_arburst == INCR && o_ddr_awburst == INCR)
        else $error("burst type is not incrementing");

    // four byte beats
    a_size: assert property (@(posedge clk_ddr) disable iff (i_rst)
        o_ddr_arsize == 3'd2 && o_ddr_awsize == 3'd2)
        else $error("burst size is not one full word");

endmodule

bind dma_ddr_port dma_ddr_port_asserts u_asserts (.*);

`default_nettype wire

// ==== verif/tb_dma_ddr_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dma_ddr_port;

    import dma_axi_pkg::*;
    import dma_cfg_pkg::*;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_BOTH} op_e;

    localparam int MEM_WORDS = 1024;
    localparam int NUM_DESC  = 6;

    // the last table column holds the beats each row moves in each direction
    // a row with both operations reads and writes disjoint regions at once
    localparam op_e TBL_OP [NUM_DESC] = '{OP_RD, OP_WR, OP_RD, OP_BOTH, OP_RD, OP_BOTH};
    localparam ddr_addr_t TBL_RD_ADDR [NUM_DESC] = '{32'h400, 32'h0, 32'h100, 32'h800, 32'h200,
                                                     32'h100};
    localparam ddr_addr_t TBL_WR_ADDR [NUM_DESC] = '{32'h0, 32'h100, 32'h0, 32'h200, 32'h0,
                                                     32'hC00};
    localparam int TBL_BURSTS [NUM_DESC] = '{3, 2, 2, 4, 4, 5};
    localparam int TBL_BEATS  [NUM_DESC] = '{12, 8, 8, 16, 16, 20};

    logic         clk_ddr = 1'b0;
    logic         i_rst;
    logic         i_rd_start;
    ddr_addr_t    i_rd_addr;
    burst_count_t i_rd_bursts;
    logic         i_wr_start;
    ddr_addr_t    i_wr_addr;
    burst_count_t i_wr_bursts;
    logic         o_rd_valid;
    ddr_data_t    o_rd_data;
    logic         i_rd_ready;
    logic         i_wr_valid;
    ddr_data_t    i_wr_data;
    logic         o_wr_ready;
    logic         o_rd_busy, o_rd_done, o_wr_busy, o_wr_done;
    logic         o_ddr_arvalid, i_ddr_arready, i_ddr_rvalid, o_ddr_rready;
    ddr_addr_t    o_ddr_araddr;
    axi_len_t     o_ddr_arlen;
    logic [AXI_SIZE_WIDTH-1:0] o_ddr_arsize;
    axi_burst_e   o_ddr_arburst;
    ddr_data_t    i_ddr_rdata;
    logic         o_ddr_awvalid, i_ddr_awready;
    ddr_addr_t    o_ddr_awaddr;
    axi_len_t     o_ddr_awlen;
    logic [AXI_SIZE_WIDTH-1:0] o_ddr_awsize;
    axi_burst_e   o_ddr_awburst;
    logic         o_ddr_wvalid, o_ddr_wlast, i_ddr_wready, i_ddr_bvalid, o_ddr_bready;
    ddr_data_t    o_ddr_wdata;
    ddr_strb_t    o_ddr_wstrb;

    // DDR model contents and the contents the testbench expects
    ddr_data_t mem     [0:MEM_WORDS-1];
    ddr_data_t ref_mem [0:MEM_WORDS-1];
    // word indices of R beats owed, AW words waiting for data, W data waiting for AW
    int        r_q [$];
    int        aw_q [$];
    ddr_data_t w_q [$];
    int        b_owed;
    int        w_seen;
    int        w_stored;
    logic      r_taken;
    logic      b_taken;
    integer    seed;
    int        cycles;
    int        cycle_limit;
    int        err_count;
    int        rd_word;
    int        rd_beats;
    int        wr_left;
    ddr_data_t wr_count;
    logic      rd_finished;
    logic      wr_finished;

    dma_ddr_port UUT (.*);

    initial begin
        forever #10 clk_ddr = ~clk_ddr;
    end

    task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            err_count++;
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // DDR model whose inputs change on the falling edge and are sampled
    // a little later, well before the rising edge uses them
    //////////////////////////////////////////////////////////////////////

    task automatic record_cycle();
        int k;
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, the run went past its limit of %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "stopped on timeout");
        end
        if (!i_rst) begin
            // a read request must stay off the bus while any write is offered
            if (o_ddr_awvalid || o_ddr_wvalid) begin
                expect_equal(32'(o_ddr_arvalid), 32'd0, "arvalid during write traffic");
            end
            if (o_ddr_arvalid && i_ddr_arready) begin
                for (k = 0; k < BURST_WORDS; k++) begin
                    r_q.push_back(int'(o_ddr_araddr >> 2) + k);
                end
            end
            if (o_ddr_awvalid && i_ddr_awready) begin
                for (k = 0; k < BURST_WORDS; k++) begin
                    aw_q.push_back(int'(o_ddr_awaddr >> 2) + k);
                end
            end
            if (o_ddr_wvalid && i_ddr_wready) begin
                expect_equal(32'(o_ddr_wlast), 32'(w_seen % 4 == 3), "wlast position");
                expect_equal(32'(o_ddr_wstrb), 32'hF, "write strobe");
                w_q.push_back(o_ddr_wdata);
                w_seen++;
            end
            // the write stream and the W channel move the same beats
            expect_equal(32'(i_wr_valid && o_wr_ready), 32'(o_ddr_wvalid && i_ddr_wready),
                         "write stream handshake");
            if (i_wr_valid && o_wr_ready) begin
                wr_count++;
                wr_left--;
            end
            if (i_ddr_rvalid && o_ddr_rready) begin
                void'(r_q.pop_front());
                r_taken = 1'b1;
            end
            if (o_rd_valid && i_rd_ready) begin
                expect_equal(o_rd_data, ref_mem[rd_word + rd_beats], "read data");
                rd_beats++;
            end
            if (i_ddr_bvalid && o_ddr_bready) begin
                b_owed--;
                b_taken = 1'b1;
            end
            // a burst is stored once its address and its data have both arrived
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                mem[aw_q.pop_front()] = w_q.pop_front();
                w_stored++;
                if (w_stored % 4 == 0) begin
                    b_owed++;
                end
            end
            if (o_rd_done) begin
                rd_finished = 1'b1;
            end
            if (o_wr_done) begin
                wr_finished = 1'b1;
            end
        end
    endtask

    always @(negedge clk_ddr) begin
        i_ddr_arready = ($random(seed) & 3) != 0;
        i_ddr_awready = ($random(seed) & 3) != 0;
        i_ddr_wready  = ($random(seed) & 3) != 0;
        i_rd_ready    = ($random(seed) & 3) != 0;
        i_wr_valid    = (($random(seed) & 3) != 0) && (wr_left > 0) && o_wr_busy;
        i_wr_data     = wr_count;
        // a raised R or B valid holds its beat until the DUT takes it
        if (!i_ddr_rvalid || r_taken) begin
            i_ddr_rvalid = (($random(seed) & 1) != 0) && (r_q.size() > 0);
            i_ddr_rdata  = (r_q.size() > 0) ? mem[r_q[0]] : '0;
        end
        if (!i_ddr_bvalid || b_taken) begin
            i_ddr_bvalid = (($random(seed) & 1) != 0) && (b_owed > 0);
        end
        r_taken = 1'b0;
        b_taken = 1'b0;
        #2;
        record_cycle();
    end

    //////////////////////////////////////////////////////////////////////
    // descriptor sequence
    //////////////////////////////////////////////////////////////////////

    task automatic run_descriptor(input int idx);
        int        k;
        int        wr_word;
        logic      do_rd;
        logic      do_wr;
        ddr_data_t wr_first;
        do_rd = (TBL_OP[idx] != OP_WR);
        do_wr = (TBL_OP[idx] != OP_RD);
        @(negedge clk_ddr);
        rd_finished = !do_rd;
        wr_finished = !do_wr;
        rd_word     = int'(TBL_RD_ADDR[idx] >> 2);
        rd_beats    = 0;
        wr_word     = int'(TBL_WR_ADDR[idx] >> 2);
        wr_first    = wr_count;
        wr_left     = do_wr ? TBL_BEATS[idx] : 0;
        i_rd_start  = do_rd;
        i_rd_addr   = TBL_RD_ADDR[idx];
        i_rd_bursts = burst_count_t'(TBL_BURSTS[idx]);
        i_wr_start  = do_wr;
        i_wr_addr   = TBL_WR_ADDR[idx];
        i_wr_bursts = burst_count_t'(TBL_BURSTS[idx]);
        @(negedge clk_ddr);
        i_rd_start = 1'b0;
        i_wr_start = 1'b0;
        expect_equal(32'({o_rd_busy, o_wr_busy}), 32'({do_rd, do_wr}), "busy after start");
        while (!(rd_finished && wr_finished)) begin
            @(negedge clk_ddr);
        end
        expect_equal(32'({o_rd_busy, o_wr_busy}), 32'd0, "busy after done");
        if (do_rd) begin
            expect_equal(32'(rd_beats), 32'(TBL_BEATS[idx]), "read beat count");
        end
        if (do_wr) begin
            expect_equal(32'(b_owed), 32'd0, "B responses still owed at write done");
            expect_equal(32'(wr_left), 32'd0, "write beats left at write done");
            for (k = 0; k < TBL_BEATS[idx]; k++) begin
                expect_equal(mem[wr_word + k], wr_first + ddr_data_t'(k), "written word");
                ref_mem[wr_word + k] = wr_first + ddr_data_t'(k);
            end
        end
    endtask

    initial begin
        int        i;
        int        total;
        ddr_data_t fill;
        seed        = 23462;
        err_count   = 0;
        cycles      = 0;
        i_rst       = 1'b1;
        i_rd_start  = 1'b0;
        i_rd_addr   = '0;
        i_rd_bursts = '0;
        i_wr_start  = 1'b0;
        i_wr_addr   = '0;
        i_wr_bursts = '0;
        i_rd_ready  = 1'b0;
        i_wr_valid  = 1'b0;
        i_wr_data   = '0;
        i_ddr_arready = 1'b0;
        i_ddr_awready = 1'b0;
        i_ddr_wready  = 1'b0;
        i_ddr_rvalid  = 1'b0;
        i_ddr_rdata   = '0;
        i_ddr_bvalid  = 1'b0;
        r_taken  = 1'b0;
        b_taken  = 1'b0;
        b_owed   = 0;
        w_seen   = 0;
        w_stored = 0;
        rd_word  = 0;
        rd_beats = 0;
        wr_left  = 0;
        wr_count = 32'h1000;
        rd_finished = 1'b0;
        wr_finished = 1'b0;
        // each word starts as its own byte address over a fixed tag
        for (i = 0; i < MEM_WORDS; i++) begin
            fill       = 32'hA500_0000 + ddr_data_t'(i * 4);
            mem[i]     = fill;
            ref_mem[i] = fill;
        end
        total = 0;
        for (i = 0; i < NUM_DESC; i++) begin
            total += (TBL_OP[i] == OP_BOTH) ? 2 * TBL_BEATS[i] : TBL_BEATS[i];
        end
        cycle_limit = 40 * total + 200;
        repeat (3) @(posedge clk_ddr);
        @(negedge clk_ddr);
        i_rst = 1'b0;
        #2;
        expect_equal(32'({o_ddr_arvalid, o_ddr_awvalid, o_ddr_wvalid, o_rd_busy, o_wr_busy,
                          o_rd_done, o_wr_done, o_wr_ready}), 32'd0, "outputs after reset");
        for (i = 0; i < NUM_DESC; i++) begin
            run_descriptor(i);
        end
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "run ended with mismatches");
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/dma_axi_pkg.sv
source/dma_cfg_pkg.sv
source/dma_feature_reader.sv
source/dma_feature_writer.sv
source/dma_ddr_prioritizer.sv
source/dma_ddr_port.sv
verif/dma_ddr_port_asserts.sv
verif/tb_dma_ddr_port.sv

// ==== Makefile ====
TOP := tb_dma_ddr_port

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation reported errors"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log
